// ==== hdl/mbu_consts.svh ====
/*
 * Sizes, I/O page and microcode addresses of the memory bank unit.
 * Included by the package and by every RTL file that needs a constant.
 */

`ifndef MBU_CONSTS_SVH
`define MBU_CONSTS_SVH

//////////////////////////////////////////////////////////////
// Register file geometry
//////////////////////////////////////////////////////////////

// Eight bank registers MB0 to MB7
`define MBU_NREGS 8

// Register select width
`define MBU_SEL_W 3

//////////////////////////////////////////////////////////////
// Address decoding
//////////////////////////////////////////////////////////////

// Microcode read and write address width
`define MBU_UADDR_W 5

// Required value of ab[7:3] for I/O addresses 0x08 to 0x0F
`define MBU_IO_PAGE 5'b00001

// Program bank (MB0) read and write address
`define MBU_UA_MBP 5'b01100

// Group of write addresses 001xx that load the AR top byte
`define MBU_UA_GRP_AR 3'b001

`endif

// ==== hdl/mbu_pkg.sv ====
/*
 * Types shared by the memory bank unit RTL and its testbench.
 * Imported with a wildcard in each module header that needs them.
 */

`include "mbu_consts.svh"

package mbu_pkg;

   // Decoder view of a microcode address
   // Page bits then the low field that picks the output line
   typedef struct packed {
      logic                      pg_dis;
      logic                      pg_en;
      logic [`MBU_UADDR_W-3:0]   low;
   } mbu_uaddr_dec_t;

   // Group view of the same address
   // Top three bits name the group, the rest index a register
   typedef struct packed {
      logic [2:0]                grp;
      logic [`MBU_UADDR_W-4:0]   idx;
   } mbu_uaddr_grp_t;

   // One microcode address word, decoded two ways
   typedef union packed {
      mbu_uaddr_dec_t dec;
      mbu_uaddr_grp_t grp;
   } mbu_uaddr_u;

   // Access strobes from the address decoder, all active high
   typedef struct packed {
      logic iombr;          // I/O access to the register page
      logic io_rd;          // ...and it is an IN
      logic io_wr;          // ...and it is an OUT
      logic read_mbp;       // Microcode read of MB0
      logic write_mbp;      // Microcode write of MB0
      logic write_ar_mbx;   // Load AR top byte from a bank register
   } mbu_strobes_t;

   // Where the register select comes from
   typedef enum logic [1:0] {
      SEL_AB,
      SEL_ZERO,
      SEL_WADDR,
      SEL_IR
   } mbu_sel_src_e;

   // Control word, one per cycle, consumed by the register file
   typedef struct packed {
      logic                    enable;       // Set the enable flag
      logic                    wr;           // Write selected register
      logic                    wr_from_db;   // Write data from db, else ibus
      logic                    rd_ibus;      // Read result to ibus
      logic                    rd_db;        // Read result to db
      logic                    rd_ar;        // Read result to aext
      logic [`MBU_SEL_W-1:0]   sel;          // Register number
   } mbu_ctl_t;

endpackage

// ==== hdl/mbu_addr_decode.sv ====
/*
 * Address decoder of the memory bank unit.
 * Turns the I/O address bus and both microcode addresses into access
 * strobes for the control table. Purely combinational.
 */

`include "mbu_consts.svh"

module mbu_addr_decode
   import mbu_pkg::*;
(
   input  logic [7:0]   ab,
   input  logic         sysdev,
   input  logic         io_rd,
   input  logic         io_wr,
   input  mbu_uaddr_u   raddr,
   input  mbu_uaddr_u   waddr,
   output mbu_strobes_t strobes
);

   // Program bank address in union form, so its fields line up
   localparam mbu_uaddr_u UA_MBP = `MBU_UA_MBP;

   logic io_page;
   logic raddr_mbp;
   logic waddr_mbp;
   logic waddr_ar;

   //////////////////////////////////////////////////////////////
   // I/O page
   //////////////////////////////////////////////////////////////

   // Addresses 0x08 to 0x0F, low three bits pick the register
   assign io_page = (ab[7:3] == `MBU_IO_PAGE);

   //////////////////////////////////////////////////////////////
   // Microcode addresses, decoder view
   //////////////////////////////////////////////////////////////

   // Mirrors a '138 with G1 on bit 3 and /G2A on bit 4
   assign raddr_mbp = (raddr.dec.pg_dis == UA_MBP.dec.pg_dis) &&
                      (raddr.dec.pg_en  == UA_MBP.dec.pg_en)  &&
                      (raddr.dec.low    == UA_MBP.dec.low);

   // Same decode on the write side
   assign waddr_mbp = (waddr.dec.pg_dis == UA_MBP.dec.pg_dis) &&
                      (waddr.dec.pg_en  == UA_MBP.dec.pg_en)  &&
                      (waddr.dec.low    == UA_MBP.dec.low);

   //////////////////////////////////////////////////////////////
   // Microcode addresses, group view
   //////////////////////////////////////////////////////////////

   // Second decoder on bits 4:2, group 001 loads the AR top byte
   assign waddr_ar = (waddr.grp.grp == `MBU_UA_GRP_AR);

   //////////////////////////////////////////////////////////////
   // Strobe word
   //////////////////////////////////////////////////////////////

   always_comb begin
      // Page hit only for a system device cycle that reads or writes
      strobes.iombr        = io_page && sysdev && (io_rd || io_wr);
      strobes.io_rd        = strobes.iombr && io_rd;
      strobes.io_wr        = strobes.iombr && io_wr;
      strobes.read_mbp     = raddr_mbp;
      strobes.write_mbp    = waddr_mbp;
      strobes.write_ar_mbx = waddr_ar;
   end

endmodule

// ==== hdl/mbu_ctl_rom.sv ====
/*
 * Control table of the memory bank unit.
 * Maps the access strobes to a control word and picks the register
 * select from the I/O address, zero, the write address or the IR.
 */

`include "mbu_consts.svh"

module mbu_ctl_rom
   import mbu_pkg::*;
(
   input  mbu_strobes_t            strobes,
   input  logic                    idxen,
   input  logic [`MBU_SEL_W-1:0]   ir,
   input  logic [`MBU_SEL_W-1:0]   ab_sel,
   input  logic [1:0]              waddr_idx,
   output mbu_ctl_t                ctl
);

   mbu_sel_src_e sel_src;

   //////////////////////////////////////////////////////////////
   // Control table
   //////////////////////////////////////////////////////////////

   // One row per access kind, I/O first as on the board ROM
   always_comb begin
      ctl.enable     = 1'b0;
      ctl.wr         = 1'b0;
      ctl.wr_from_db = 1'b0;
      ctl.rd_ibus    = 1'b0;
      ctl.rd_db      = 1'b0;
      ctl.rd_ar      = 1'b0;
      sel_src        = SEL_ZERO;

      casez ({strobes.iombr, strobes.read_mbp, strobes.write_mbp,
              strobes.write_ar_mbx})
         // IN or OUT to 0x08..0x0F
         4'b1???: begin
            sel_src        = SEL_AB;
            ctl.enable     = 1'b1;
            // OUT stores db
            ctl.wr         = strobes.io_wr;
            ctl.wr_from_db = strobes.io_wr;
            // IN drives db back
            ctl.rd_db      = strobes.io_rd;
         end
         // Microcode reads the program bank onto ibus
         4'b01??: begin
            sel_src     = SEL_ZERO;
            ctl.rd_ibus = 1'b1;
         end
         // Microcode writes the program bank from ibus
         4'b001?: begin
            sel_src = SEL_ZERO;
            ctl.wr  = 1'b1;
         end
         // AR top byte load, indexed or not
         4'b0001: begin
            sel_src   = idxen ? SEL_IR : SEL_WADDR;
            ctl.rd_ar = 1'b1;
         end
         // Idle
         default: begin
            sel_src = SEL_ZERO;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////
   // Register select multiplexer
   //////////////////////////////////////////////////////////////

   // Four sources, formerly two '244s wired together
   always_comb begin
      unique case (sel_src)
         SEL_AB:    ctl.sel = ab_sel;
         SEL_ZERO:  ctl.sel = '0;
         SEL_WADDR: ctl.sel = {1'b0, waddr_idx};
         SEL_IR:    ctl.sel = ir;
         default:   ctl.sel = '0;
      endcase
   end

endmodule

// ==== hdl/mbu_regfile.sv ====
/*
 * Bank register file of the memory bank unit.
 * Holds MB0 to MB7 and the enable flag, applies the control word at each
 * clock and registers the read result onto one output for one cycle.
 */

`include "mbu_consts.svh"

module mbu_regfile
   import mbu_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  mbu_ctl_t   ctl,
   input  logic [7:0] ibus_in,
   input  logic [7:0] db_in,
   input  logic       fp_rom,
   output logic [7:0] ibus_out,
   output logic       ibus_oe,
   output logic [7:0] db_out,
   output logic       db_oe,
   output logic [7:0] aext,
   output logic       ar_mbx_we
);

   // Bank registers
   logic [7:0] regs [`MBU_NREGS];

   // Cleared at reset, set by the first I/O access to the page
   logic       en_q;

   logic       en_now;
   logic [7:0] wdata;
   logic [7:0] rd_val;

   //////////////////////////////////////////////////////////////
   // Read and write data paths
   //////////////////////////////////////////////////////////////

   // OUT writes take db, microcode writes take ibus
   assign wdata = ctl.wr_from_db ? db_in : ibus_in;

   // Enabling access already sees the enabled file
   assign en_now = en_q || ctl.enable;

   // Disabled unit reads as the front-panel ROM/RAM switch in bit 7
   assign rd_val = en_now ? regs[ctl.sel] : {fp_rom, 7'b000_0000};

   //////////////////////////////////////////////////////////////
   // Registers and enable flag
   //////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         en_q <= 1'b0;
         for (int i = 0; i < `MBU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (ctl.enable) begin
            en_q <= 1'b1;
         end
         // Stored even while disabled, only the read path is masked
         if (ctl.wr) begin
            regs[ctl.sel] <= wdata;
         end
      end
   end

   //////////////////////////////////////////////////////////////
   // Registered outputs
   //////////////////////////////////////////////////////////////

   // Exactly one destination per read, idle outputs sit at zero
   always_ff @(posedge clk) begin
      if (rst) begin
         ibus_out  <= '0;
         ibus_oe   <= 1'b0;
         db_out    <= '0;
         db_oe     <= 1'b0;
         aext      <= '0;
         ar_mbx_we <= 1'b0;
      end else begin
         // Microcode read of MB0
         ibus_oe  <= ctl.rd_ibus;
         ibus_out <= ctl.rd_ibus ? rd_val : 8'h00;

         // IN instruction
         db_oe  <= ctl.rd_db;
         db_out <= ctl.rd_db ? rd_val : 8'h00;

         // AR top byte, low when nothing drives it
         ar_mbx_we <= ctl.rd_ar;
         aext      <= ctl.rd_ar ? rd_val : 8'h00;
      end
   end

endmodule

// ==== hdl/mbu.sv ====
/*
 * Memory bank unit top level.
 * Eight bank registers extending processor addresses to 24 bits, reached
 * by I/O at 0x08 to 0x0F, by microcode and by AR top byte loads.
 */

`include "mbu_consts.svh"

module mbu
   import mbu_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`MBU_UADDR_W-1:0]   raddr,
   input  logic [`MBU_UADDR_W-1:0]   waddr,
   input  logic                      idxen,
   input  logic [`MBU_SEL_W-1:0]     ir,
   input  logic [7:0]                ibus_in,
   input  logic [7:0]                ab,
   input  logic [7:0]                db_in,
   input  logic                      sysdev,
   input  logic                      io_rd,
   input  logic                      io_wr,
   input  logic                      fp_rom,
   output logic [7:0]                ibus_out,
   output logic                      ibus_oe,
   output logic [7:0]                db_out,
   output logic                      db_oe,
   output logic [7:0]                aext,
   output logic                      ar_mbx_we
);

   mbu_uaddr_u   raddr_u;
   mbu_uaddr_u   waddr_u;
   mbu_strobes_t strobes;
   mbu_ctl_t     ctl;

   // Microcode addresses seen through both union views
   assign raddr_u = raddr;
   assign waddr_u = waddr;

   //////////////////////////////////////////////////////////////
   // Decode, control, register file
   //////////////////////////////////////////////////////////////

   mbu_addr_decode addr_decode_i (
      .ab      (ab),
      .sysdev  (sysdev),
      .io_rd   (io_rd),
      .io_wr   (io_wr),
      .raddr   (raddr_u),
      .waddr   (waddr_u),
      .strobes (strobes)
   );

   // Register number comes from ab[2:0] or waddr[1:0] among others
   mbu_ctl_rom ctl_rom_i (
      .strobes   (strobes),
      .idxen     (idxen),
      .ir        (ir),
      .ab_sel    (ab[2:0]),
      .waddr_idx (waddr_u.grp.idx),
      .ctl       (ctl)
   );

   mbu_regfile regfile_i (
      .clk       (clk),
      .rst       (rst),
      .ctl       (ctl),
      .ibus_in   (ibus_in),
      .db_in     (db_in),
      .fp_rom    (fp_rom),
      .ibus_out  (ibus_out),
      .ibus_oe   (ibus_oe),
      .db_out    (db_out),
      .db_oe     (db_oe),
      .aext      (aext),
      .ar_mbx_we (ar_mbx_we)
   );

endmodule

// ==== dv/mbu_props.sv ====
/*
 * Concurrent checks on the bank register file, bound into mbu_regfile.
 * Failed checks are also counted for the testbench summary.
 */

module mbu_props
   import mbu_pkg::*;
(
   input logic     clk,
   input logic     rst,
   input mbu_ctl_t ctl,
   input logic     ibus_oe,
   input logic     db_oe,
   input logic     ar_mbx_we
);

   // Read by the testbench at the end of the run
   int unsigned assert_fails = 0;

   //////////////////////////////////////////////////////////////
   // Output and control word exclusivity
   //////////////////////////////////////////////////////////////

   // A read result lands on one output only
   one_oe_a: assert property (@(posedge clk) disable iff (rst)
      $onehot0({ibus_oe, db_oe, ar_mbx_we}))
      else begin
         $error("more than one output enable high");
         assert_fails++;
      end

   // Writes carry at most one read destination
   wr_one_dest_a: assert property (@(posedge clk) disable iff (rst)
      ctl.wr |-> $onehot0({ctl.rd_ibus, ctl.rd_db, ctl.rd_ar}))
      else begin
         $error("write control word names two read destinations");
         assert_fails++;
      end

   //////////////////////////////////////////////////////////////
   // Reset
   //////////////////////////////////////////////////////////////

   // Output enables clear one edge after reset is seen
   rst_oe_low_a: assert property (@(posedge clk)
      rst |=> (!ibus_oe && !db_oe && !ar_mbx_we))
      else begin
         $error("output enable high during reset");
         assert_fails++;
      end

endmodule

// Attached to every register file instance
bind mbu_regfile mbu_props props_i (
   .clk       (clk),
   .rst       (rst),
   .ctl       (ctl),
   .ibus_oe   (ibus_oe),
   .db_oe     (db_oe),
   .ar_mbx_we (ar_mbx_we)
);

// ==== dv/mbu_tb.sv ====
/*
 * Testbench for the memory bank unit. Drives xorshift random accesses,
 * predicts every read with a register model one cycle ahead and prints
 * one line per test and a closing summary.
 */

`include "mbu_consts.svh"

module mbu_tb;

   localparam int RESET_CYCLES = 10;
   localparam int N_POWER      = 16;
   localparam int N_IO         = 40;
   localparam int N_MBP        = 8;
   localparam int N_AR         = 24;
   localparam int N_MIX        = 400;
   // Each test closes with one idle cycle that collects its last read
   localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * (N_POWER + 1) + (N_IO + 1) +
                                 (3 * N_MBP + 1) + (N_AR + 1) + (N_MIX + 1) + 20;

   // One cycle of DUT input, at most one access in it
   typedef struct packed {
      logic [4:0] raddr;
      logic [4:0] waddr;
      logic       idxen;
      logic [2:0] ir;
      logic [7:0] ibus_in;
      logic [7:0] ab;
      logic [7:0] db_in;
      logic       sysdev;
      logic       io_rd;
      logic       io_wr;
   } access_t;

   // Output enable plus data byte
   typedef struct packed {
      logic       oe;
      logic [7:0] val;
   } result_t;

   logic       clk = 1'b0;
   logic       rst;
   logic [4:0] raddr;
   logic [4:0] waddr;
   logic       idxen;
   logic [2:0] ir;
   logic [7:0] ibus_in;
   logic [7:0] ab;
   logic [7:0] db_in;
   logic       sysdev;
   logic       io_rd;
   logic       io_wr;
   logic       fp_rom;
   logic [7:0] ibus_out;
   logic       ibus_oe;
   logic [7:0] db_out;
   logic       db_oe;
   logic [7:0] aext;
   logic       ar_mbx_we;

   // Reference model state and the results due next cycle
   logic [7:0]  model_regs [8];
   logic        model_en;
   logic        fp_sel;
   result_t     exp_ibus;
   result_t     exp_db;
   result_t     exp_aext;

   logic [31:0] rng = 32'd37837;
   int          cycles = 0;
   int          test_errs = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int unsigned assert_fails;

   always #50 clk = ~clk;

   mbu dut_i (.*);

   // Run limit from the test lengths
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the run did not reach its end", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////
   // Random numbers and stimulus
   //////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng = xorshift32(rng);
      r = rng;
   endtask

   // Kinds 0-1 OUT, 2 IN, 3 miss, 4 MB0 read, 5 MB0 write, 6-7 AR load
   function automatic access_t make_access(input logic [2:0] kind, input logic [31:0] r);
      access_t a;
      a = '0;
      a.ibus_in = r[15:8];
      a.db_in   = r[15:8];
      case (kind)
         3'd0, 3'd1, 3'd2: begin
            a.ab     = {`MBU_IO_PAGE, r[18:16]};
            a.sysdev = 1'b1;
            a.io_wr  = (kind != 3'd2);
            a.io_rd  = (kind == 3'd2);
         end
         3'd3: begin
            // Any address off the page, or on it without sysdev
            if (r[9])
               a.ab = (r[7:3] == `MBU_IO_PAGE) ? {5'b00000, r[2:0]} : r[7:0];
            else
               a.ab = {`MBU_IO_PAGE, r[18:16]};
            a.sysdev = r[9];
            a.io_rd  = r[10];
            a.io_wr  = !r[10];
         end
         3'd4: a.raddr = `MBU_UA_MBP;
         3'd5: a.waddr = `MBU_UA_MBP;
         default: begin
            a.waddr = {`MBU_UA_GRP_AR, r[20:19]};
            a.idxen = r[21];
            a.ir    = r[24:22];
         end
      endcase
      return a;
   endfunction

   //////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////

   // Disabled unit shows the ROM/RAM switch in bit 7
   function automatic logic [7:0] bank_value(input logic [2:0] sel);
      return model_en ? model_regs[sel] : {fp_sel, 7'b000_0000};
   endfunction

   // Result due one cycle after the access, writes land at the same edge
   task automatic model_step(input access_t a);
      logic       io_hit;
      logic [2:0] sel;
      exp_ibus = '0;
      exp_db   = '0;
      exp_aext = '0;
      io_hit = a.sysdev && (a.io_rd || a.io_wr) && (a.ab[7:3] == `MBU_IO_PAGE);
      if (io_hit) begin
         model_en = 1'b1;
         if (a.io_rd)
            exp_db = {1'b1, model_regs[a.ab[2:0]]};
         if (a.io_wr)
            model_regs[a.ab[2:0]] = a.db_in;
      end else if (a.raddr == `MBU_UA_MBP) begin
         exp_ibus = {1'b1, bank_value(3'd0)};
      end else if (a.waddr == `MBU_UA_MBP) begin
         model_regs[0] = a.ibus_in;
      end else if (a.waddr[4:2] == `MBU_UA_GRP_AR) begin
         sel = a.idxen ? a.ir : {1'b0, a.waddr[1:0]};
         exp_aext = {1'b1, bank_value(sel)};
      end
   endtask

   //////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////

   // Data bytes count with their enable, and as zero while reset is held
   task automatic compare_result(input string test, input string port,
                                 input result_t exp, input result_t act);
      if (act.oe !== exp.oe) begin
         test_errs++;
         if (exp.oe)
            $display("%s: no %s enable where a read result was due", test, port);
         else
            $display("%s: %s enable high with no read pending", test, port);
      end else if ((exp.oe || rst) && act.val !== exp.val) begin
         test_errs++;
         $display("ERR %s %s expected %02h actual %02h", test, port, exp.val, act.val);
      end
   endtask

   task automatic check_ibus(input string test, input result_t exp);
      compare_result(test, "ibus", exp, {ibus_oe, ibus_out});
   endtask

   task automatic check_db(input string test, input result_t exp);
      compare_result(test, "db", exp, {db_oe, db_out});
   endtask

   task automatic check_aext(input string test, input result_t exp);
      compare_result(test, "aext", exp, {ar_mbx_we, aext});
   endtask

   //////////////////////////////////////////////////////////////
   // Test sequencing
   //////////////////////////////////////////////////////////////

   // Counts the test and prints its one-line result
   task automatic close_test(input string name);
      if (test_errs == 0)
         tests_passed++;
      else
         tests_failed++;
      $display("Test %s: %s, %0d mismatches", name, (test_errs == 0) ? "ok" : "bad", test_errs);
      test_errs = 0;
   endtask

   // Drive at the rising edge, check the previous access at the falling one
   task automatic run_access(input string test, input access_t a);
      @(posedge clk);
      raddr   <= a.raddr;
      waddr   <= a.waddr;
      idxen   <= a.idxen;
      ir      <= a.ir;
      ibus_in <= a.ibus_in;
      ab      <= a.ab;
      db_in   <= a.db_in;
      sysdev  <= a.sysdev;
      io_rd   <= a.io_rd;
      io_wr   <= a.io_wr;
      fp_rom  <= fp_sel;
      @(negedge clk);
      check_ibus(test, exp_ibus);
      check_db(test, exp_db);
      check_aext(test, exp_aext);
      model_step(a);
   endtask

   // Modes 0 power-on, 1 I/O, 2 program bank, 3 AR load, else mixed
   task automatic run_test(input string name, input int mode, input int n);
      logic [31:0] r;
      logic [2:0]  kind;
      for (int i = 0; i < n; i++) begin
         next_rand(r);
         case (mode)
            0: kind = r[0] ? 3'd4 : 3'd6;
            1: kind = (i == 0) ? 3'd0 : {1'b0, r[30:29]};
            2: begin
               // MB0 write, MB0 read, then IN from 0x08
               kind = (i % 3 == 0) ? 3'd5 : (i % 3 == 1) ? 3'd4 : 3'd2;
               r = r & 32'hFFF8_FFFF;
            end
            3: kind = 3'd6;
            default: kind = r[31:29];
         endcase
         run_access(name, make_access(kind, r));
      end
      run_access(name, '0);
      close_test(name);
   endtask

   initial begin
      rst      = 1'b1;
      raddr    = '0;
      waddr    = '0;
      idxen    = 1'b0;
      ir       = '0;
      ibus_in  = '0;
      ab       = '0;
      db_in    = '0;
      sysdev   = 1'b0;
      io_rd    = 1'b0;
      io_wr    = 1'b0;
      fp_rom   = 1'b0;
      fp_sel   = 1'b0;
      model_en = 1'b0;
      for (int i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end
      exp_ibus = '0;
      exp_db   = '0;
      exp_aext = '0;

      // Outputs idle and zero late in reset
      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_ibus("reset", '0);
      check_db("reset", '0);
      check_aext("reset", '0);
      close_test("reset");
      @(posedge clk);
      rst <= 1'b0;

      run_test("power_on_rom0", 0, N_POWER);
      fp_sel = 1'b1;
      run_test("power_on_rom1", 0, N_POWER);
      run_test("io_access", 1, N_IO);
      run_test("program_bank", 2, 3 * N_MBP);
      run_test("ar_load", 3, N_AR);
      run_test("random_mix", 4, N_MIX);

      assert_fails = dut_i.regfile_i.props_i.assert_fails;
      $display("Summary: %0d tests passed, %0d tests failed, %0d assertion failures",
               tests_passed, tests_failed, assert_fails);
      if (tests_failed == 0 && assert_fails == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== mbu.f ====
+incdir+hdl
hdl/mbu_pkg.sv
hdl/mbu_addr_decode.sv
hdl/mbu_ctl_rom.sv
hdl/mbu_regfile.sv
hdl/mbu.sv
dv/mbu_props.sv
dv/mbu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the MBU testbench with Verilator, runs it and scans the log.
# Exits non-zero on a build error or when the run reports failure.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -j 0 --top-module mbu_tb -f mbu.f -o mbu_sim || exit 1

# Assertion errors are counted by the testbench, so the run must not stop on the first
./obj_dir/mbu_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
